// ==== verilog/control_pkg.sv ====
package control_pkg;

	typedef enum logic [4:0] {
		S_RESET, S_FETCH, S_FETCH2, S_EVAL,
		S_ARG, S_ARG2,
		S_ALU, S_ALU2, S_ALU3, S_ALU4,
		S_MDR2RA, S_LDIU, S_BRANCH,
		S_LOAD, S_LOAD2, S_LOAD3,
		S_LOADD, S_LOADD2, S_LOADD3,
		S_STORE, S_STORE2, S_STORE3,
		S_STORED, S_STORED2, S_STORE4, S_STORE5,
		S_TERM, S_HALT
	} state_t;

	typedef enum logic [3:0] {
		T_INH    = 4'h0,
		T_ALU    = 4'h6,
		T_LDI    = 4'h8,
		T_LOAD   = 4'h9,
		T_STORE  = 4'ha,
		T_BRANCH = 4'hb
	} insn_class_t;

	typedef struct packed {
		logic [3:0]  cls;
		logic [3:0]  op;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [10:0] rsvd;
		logic        size; // argument word follows
	} insn_reg_t;

	typedef struct packed {
		logic [3:0]  cls;
		logic [3:0]  op;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [14:0] uval; // also the signed offset
		logic        size;
	} insn_imm_t;

	typedef union packed {
		insn_reg_t r;
		insn_imm_t i;
	} insn_u;

	typedef struct packed {
		insn_class_t cls;
		logic [3:0]  op;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic        has_arg;
		logic        illegal;
	} decoded_t;

	typedef struct packed {
		logic ltu;
		logic lt;
		logic eq;
	} ccr_flags_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_LSHIFT, ALU_RSHIFTA, ALU_RSHIFTL
	} alufunc_t;

	typedef enum logic [1:0] {ALU_B, ALU_4, ALU_SVAL} alu_in_t;
	typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_UVAL, REG_B} reg_in_t;
	typedef enum logic [2:0] {MDR_MDR, MDR_IBUS, MDR_DBUS, MDR_ALU, MDR_A} mdr_in_t;
	typedef enum logic [1:0] {MAR_MAR, MAR_IBUS, MAR_ALU, MAR_DBUS} mar_t;
	typedef enum logic [1:0] {PC_PC, PC_NEXT, PC_REL, PC_MAR} pc_t;
	typedef enum logic [1:0] {ADDR_PC, ADDR_MAR} addr_t;
	typedef enum logic [1:0] {CCR_CCR, CCR_ALU} ccr_t;

	typedef struct packed {
		logic       ir_write;
		ccr_t       ccrsel;
		alufunc_t   alu_func;
		alu_in_t    alu2sel;
		reg_in_t    regsel;
		logic [3:0] reg_read_addr1;
		logic [3:0] reg_read_addr2;
		logic [3:0] reg_write_addr;
		logic [1:0] reg_write;
		logic       a_write;
		logic       b_write;
		mdr_in_t    mdrsel;
		mar_t       marsel;
		pc_t        pcsel;
		addr_t      addrsel;
	} datapath_ctl_t;

	typedef struct packed {
		logic ins_start;
		logic dat_start;
		logic dat_write;
	} bus_req_t;

	typedef struct packed {
		logic ins_done;
		logic dat_done;
	} bus_done_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       write;
		logic [3:0] byteenable;
	} dat_bus_t;

	typedef struct packed {
		logic cyc;
		logic stb;
	} ins_bus_t;

	localparam logic [1:0] REG_WRITE_NONE = 2'b00;
	localparam logic [1:0] REG_WRITE_DW   = 2'b11; // full word
	localparam logic [3:0] BE_WORD        = 4'b1111;
	localparam logic [1:0] OP_HALF        = 2'd1;
	localparam logic [1:0] OP_BYTE        = 2'd2;
	localparam logic [3:0] INH_NOP        = 4'h0;
	localparam logic [3:0] INH_HALT       = 4'h4;

	localparam logic [3:0] BR_BRA  = 4'd0;
	localparam logic [3:0] BR_BEQ  = 4'd1;
	localparam logic [3:0] BR_BNE  = 4'd2;
	localparam logic [3:0] BR_BGTU = 4'd3;
	localparam logic [3:0] BR_BGT  = 4'd4;
	localparam logic [3:0] BR_BGE  = 4'd5;
	localparam logic [3:0] BR_BLE  = 4'd6;
	localparam logic [3:0] BR_BLT  = 4'd7;
	localparam logic [3:0] BR_BGEU = 4'd8;
	localparam logic [3:0] BR_BLTU = 4'd9;
	localparam logic [3:0] BR_BLEU = 4'd10;

endpackage

// ==== verilog/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder (
	input  control_pkg::insn_u    ir,
	output control_pkg::decoded_t dec
);
	import control_pkg::*;

	always_comb
	begin
		dec.cls     = insn_class_t'(ir.r.cls);
		dec.op      = ir.r.op;
		dec.ra      = ir.r.ra;
		dec.rb      = ir.r.rb;
		dec.rc      = ir.r.rc;
		dec.has_arg = ir.r.size;

		case (ir.r.cls)
			T_INH:
				dec.illegal = !(ir.r.op inside {INH_NOP, INH_HALT});
			T_LDI, T_LOAD, T_STORE:
				dec.illegal = 1'b0; // short or long form
			T_ALU, T_BRANCH:
				dec.illegal = ir.r.size; // no argument word here
			default:
				dec.illegal = 1'b1;
		endcase
	end

endmodule

// ==== verilog/branch_resolver.sv ====
`timescale 1ns/1ps

module branch_resolver (
	input  control_pkg::decoded_t   dec,
	input  control_pkg::ccr_flags_t ccr,
	output logic                    taken
);
	import control_pkg::*;

	always_comb
	begin
		case (dec.op)
			BR_BRA:  taken = 1'b1;
			BR_BEQ:  taken = ccr.eq;
			BR_BNE:  taken = !ccr.eq;
			BR_BGTU: taken = !(ccr.ltu | ccr.eq);
			BR_BGT:  taken = !(ccr.lt | ccr.eq);
			BR_BGE:  taken = !ccr.lt;
			BR_BLE:  taken = ccr.lt | ccr.eq;
			BR_BLT:  taken = ccr.lt;
			BR_BGEU: taken = !ccr.ltu;
			BR_BLTU: taken = ccr.ltu;
			BR_BLEU: taken = ccr.ltu | ccr.eq;
			default: taken = 1'b0; // brn
		endcase
	end

endmodule

// ==== verilog/bus_sequencer.sv ====
`timescale 1ns/1ps

module bus_sequencer (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  control_pkg::bus_req_t  req,
	input  control_pkg::decoded_t  dec,
	input  logic [1:0]             datbus_align,
	input  logic                   datbus_ack,
	input  logic                   insbus_ack,
	output control_pkg::dat_bus_t  datbus,
	output control_pkg::ins_bus_t  insbus,
	output control_pkg::bus_done_t done
);
	import control_pkg::*;

	logic [3:0] lanes;

	// lane 3 is the lowest address
	always_comb
	begin
		case (dec.op[1:0])
			OP_HALF: lanes = datbus_align[1] ? 4'b0011 : 4'b1100;
			OP_BYTE: lanes = 4'b1000 >> datbus_align;
			default: lanes = BE_WORD;
		endcase
	end

	assign done = '{
		ins_done: insbus.cyc & insbus_ack,
		dat_done: datbus.cyc & datbus_ack
	};

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			insbus.cyc <= 1'b0;
			insbus.stb <= 1'b0;
		end
		else if (req.ins_start)
		begin
			insbus.cyc <= 1'b1;
			insbus.stb <= 1'b1;
		end
		else
		begin
			insbus.stb <= 1'b0; // single strobe cycle
			if (done.ins_done)
				insbus.cyc <= 1'b0;
		end
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			datbus.cyc        <= 1'b0;
			datbus.stb        <= 1'b0;
			datbus.write      <= 1'b0;
			datbus.byteenable <= BE_WORD;
		end
		else if (req.dat_start)
		begin
			datbus.cyc        <= 1'b1;
			datbus.stb        <= 1'b1;
			datbus.write      <= req.dat_write;
			datbus.byteenable <= lanes;
		end
		else
		begin
			datbus.stb <= 1'b0;
			if (done.dat_done)
			begin
				datbus.cyc   <= 1'b0;
				datbus.write <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  control_pkg::decoded_t      dec,
	input  control_pkg::insn_u         ir,
	input  logic                       taken,
	input  control_pkg::bus_done_t     done,
	output control_pkg::datapath_ctl_t ctl,
	output control_pkg::bus_req_t      req,
	output logic                       halt
);
	import control_pkg::*;

	state_t state;
	state_t state_next;

	assign halt = (state == S_HALT);

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
			state <= S_RESET;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next         = state;
		req.ins_start      = 1'b0;
		req.dat_start      = 1'b0;
		req.dat_write      = 1'b0;
		ctl.ir_write       = 1'b0;
		ctl.ccrsel         = CCR_CCR;
		ctl.alu_func       = ALU_ADD;
		ctl.alu2sel        = ALU_B;
		ctl.regsel         = REG_ALU;
		ctl.reg_read_addr1 = dec.ra;
		ctl.reg_read_addr2 = dec.rb;
		ctl.reg_write_addr = dec.ra;
		ctl.reg_write      = REG_WRITE_NONE;
		ctl.a_write        = 1'b0;
		ctl.b_write        = 1'b0;
		ctl.mdrsel         = MDR_MDR;
		ctl.marsel         = MAR_MAR;
		ctl.pcsel          = PC_PC;
		ctl.addrsel        = ADDR_PC;

		case (state)
			S_RESET: state_next = S_FETCH;
			S_FETCH:
			begin
				req.ins_start = 1'b1;
				ctl.ir_write  = 1'b1;
				state_next    = S_FETCH2;
			end
			S_FETCH2:
			begin
				ctl.ir_write = 1'b1; // ir follows the bus
				if (done.ins_done)
				begin
					ctl.pcsel  = PC_NEXT;
					state_next = S_EVAL;
				end
			end
			S_EVAL:
			begin
				ctl.a_write = 1'b1; // preload rA and rB
				ctl.b_write = 1'b1;
				if (dec.illegal)
					state_next = S_HALT;
				else if (dec.has_arg)
					state_next = S_ARG;
				else
					case (dec.cls)
						T_INH:    state_next = (dec.op == INH_HALT) ? S_HALT : S_FETCH;
						T_ALU:    state_next = S_ALU;
						T_LDI:    state_next = S_LDIU;
						T_LOAD:   state_next = S_LOAD;
						T_STORE:  state_next = S_STORE;
						T_BRANCH: state_next = S_BRANCH;
						default:  state_next = S_HALT;
					endcase
			end
			S_ARG:
			begin
				req.ins_start = 1'b1;
				ctl.marsel    = MAR_IBUS;
				ctl.mdrsel    = MDR_IBUS;
				state_next    = S_ARG2;
			end
			S_ARG2:
			begin
				ctl.marsel = MAR_IBUS;
				ctl.mdrsel = MDR_IBUS;
				if (done.ins_done)
				begin
					ctl.pcsel = PC_NEXT;
					case (dec.cls)
						T_INH:   state_next = (dec.op == INH_HALT) ? S_HALT : S_FETCH;
						T_LDI:   state_next = S_MDR2RA;
						T_LOAD:  state_next = S_LOADD;
						T_STORE: state_next = S_STORED;
						default: state_next = S_HALT;
					endcase
				end
			end
			S_ALU:
			begin
				ctl.reg_read_addr1 = dec.rb;
				ctl.reg_read_addr2 = dec.rc;
				ctl.a_write        = 1'b1;
				ctl.b_write        = 1'b1;
				state_next         = dec.op[3] ? S_ALU3 : S_ALU2;
			end
			S_ALU2:
			begin
				ctl.alu_func = alufunc_t'(dec.op[2:0]);
				state_next   = S_ALU4;
			end
			S_ALU3:
			begin
				ctl.alu_func = alufunc_t'(dec.op[2:0]);
				ctl.alu2sel  = ALU_SVAL; // immediate operand
				state_next   = S_ALU4;
			end
			S_ALU4:
			begin
				ctl.mdrsel = MDR_ALU;
				state_next = S_MDR2RA;
			end
			S_MDR2RA:
			begin
				ctl.regsel    = REG_MDR;
				ctl.reg_write = REG_WRITE_DW;
				state_next    = S_FETCH;
			end
			S_LDIU:
			begin
				ctl.regsel    = REG_UVAL;
				ctl.reg_write = REG_WRITE_DW;
				state_next    = S_FETCH;
			end
			S_BRANCH:
			begin
				if (taken)
					ctl.pcsel = PC_REL;
				state_next = S_FETCH;
			end
			S_LOAD:
			begin
				ctl.reg_read_addr1 = ir.i.rb; // base register
				ctl.a_write        = 1'b1;
				state_next         = S_LOAD2;
			end
			S_LOAD2:
			begin
				ctl.alu2sel = ALU_SVAL;
				state_next  = S_LOAD3;
			end
			S_LOAD3:
			begin
				ctl.marsel = MAR_ALU;
				state_next = S_LOADD2;
			end
			S_LOADD: state_next = S_LOADD2; // MAR came from the argument word
			S_LOADD2:
			begin
				ctl.addrsel   = ADDR_MAR;
				ctl.mdrsel    = MDR_DBUS;
				req.dat_start = 1'b1;
				state_next    = S_LOADD3;
			end
			S_LOADD3:
			begin
				ctl.addrsel = ADDR_MAR;
				ctl.mdrsel  = MDR_DBUS;
				if (done.dat_done)
					state_next = S_MDR2RA;
			end
			S_STORE:
			begin
				ctl.reg_read_addr1 = ir.i.rb;
				ctl.a_write        = 1'b1;
				state_next         = S_STORE2;
			end
			S_STORE2:
			begin
				ctl.alu2sel = ALU_SVAL;
				ctl.a_write = 1'b1; // A <= rA after the sum
				state_next  = S_STORE3;
			end
			S_STORE3:
			begin
				ctl.marsel = MAR_ALU;
				ctl.mdrsel = MDR_A;
				state_next = S_STORE4;
			end
			S_STORED:
			begin
				ctl.a_write = 1'b1;
				state_next  = S_STORED2;
			end
			S_STORED2:
			begin
				ctl.mdrsel = MDR_A;
				state_next = S_STORE4;
			end
			S_STORE4:
			begin
				ctl.addrsel   = ADDR_MAR;
				req.dat_start = 1'b1;
				req.dat_write = 1'b1;
				state_next    = S_STORE5;
			end
			S_STORE5:
			begin
				ctl.addrsel = ADDR_MAR;
				if (done.dat_done)
					state_next = S_TERM;
			end
			S_TERM: state_next = S_FETCH;
			S_HALT: state_next = S_HALT;
			default: state_next = S_HALT;
		endcase
	end

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  control_pkg::insn_u         ir,
	input  control_pkg::ccr_flags_t    ccr,
	input  logic                       datbus_ack,
	input  logic [1:0]                 datbus_align,
	input  logic                       insbus_ack,
	output control_pkg::datapath_ctl_t ctl,
	output control_pkg::dat_bus_t      datbus,
	output control_pkg::ins_bus_t      insbus,
	output logic                       halt
);
	import control_pkg::*;

	decoded_t  dec;
	logic      taken;
	bus_req_t  req;
	bus_done_t done;

	insn_decoder u_decoder (
		.ir  (ir),
		.dec (dec)
	);

	branch_resolver u_branch (
		.dec   (dec),
		.ccr   (ccr),
		.taken (taken)
	);

	bus_sequencer u_bus (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req          (req),
		.dec          (dec),
		.datbus_align (datbus_align),
		.datbus_ack   (datbus_ack),
		.insbus_ack   (insbus_ack),
		.datbus       (datbus),
		.insbus       (insbus),
		.done         (done)
	);

	control_fsm u_fsm (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.dec   (dec),
		.ir    (ir),
		.taken (taken),
		.done  (done),
		.ctl   (ctl),
		.req   (req),
		.halt  (halt)
	);

endmodule

// ==== tb/control_checks.svh ====
// what one instruction window showed on the outputs
typedef struct packed {
	logic [7:0] n_arg;
	logic [7:0] n_dat;
	logic [7:0] n_wr;
	logic [7:0] n_rel;
	logic [7:0] n_sval;
	logic       dat_write;
	logic [3:0] be;
	logic [1:0] wr_code;
	reg_in_t    regsel;
	logic [3:0] waddr;
	alufunc_t   func;
	logic       halted;
} obs_t;

function automatic logic is_illegal(input insn_u w);
	logic known;
	logic arg_ok;
	known  = w.r.cls inside {T_INH, T_ALU, T_LDI, T_LOAD, T_STORE, T_BRANCH};
	arg_ok = !w.r.size || (w.r.cls inside {T_INH, T_LDI, T_LOAD, T_STORE});
	if (w.r.cls == T_INH && w.r.op != INH_NOP && w.r.op != INH_HALT)
		return 1'b1;
	return !known || !arg_ok;
endfunction

function automatic logic branch_taken(input logic [3:0] cond, input ccr_flags_t f);
	logic gtu;
	logic gt;
	gtu = !f.ltu && !f.eq;
	gt  = !f.lt && !f.eq;
	case (cond)
		4'd0:    return 1'b1;
		4'd1:    return f.eq;
		4'd2:    return !f.eq;
		4'd3:    return gtu;
		4'd4:    return gt;
		4'd5:    return !f.lt;
		4'd6:    return !gt; // lt or eq
		4'd7:    return f.lt;
		4'd8:    return !f.ltu;
		4'd9:    return f.ltu;
		4'd10:   return !gtu;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [3:0] lane_mask(input logic [3:0] op, input logic [1:0] align);
	if (op[1:0] == OP_HALF)
		return align[1] ? 4'b0011 : 4'b1100;
	if (op[1:0] == OP_BYTE)
		return 4'b0001 << (2'd3 - align); // align 0 is the top lane
	return BE_WORD;
endfunction

task automatic check_pc(input string name, input pc_t got, input pc_t exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("Error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
	end
endtask

task automatic check_alu(input string name, input alufunc_t got, input alufunc_t exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("Error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
	end
endtask

task automatic check_reg_in(input string name, input reg_in_t got, input reg_in_t exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("Error at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
	end
endtask

task automatic check_be(input string name, input logic [3:0] got, input logic [3:0] exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_num(input string name, input int got, input int exp);
	if (got != exp)
	begin
		value_errors++;
		$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
	end
endtask

task automatic expect_window(input insn_u w, input logic [1:0] align, input ccr_flags_t f,
		input obs_t o);
	logic ill;
	logic mem;
	logic writes;
	logic alu;
	ill    = is_illegal(w);
	mem    = !ill && (w.r.cls == T_LOAD || w.r.cls == T_STORE);
	writes = !ill && (w.r.cls inside {T_ALU, T_LDI, T_LOAD});
	alu    = !ill && w.r.cls == T_ALU;
	check_bit("halt", o.halted, ill || (w.r.cls == T_INH && w.r.op == INH_HALT));
	check_num("insbus.stb count", o.n_arg, (!ill && w.r.size) ? 1 : 0); // argument word
	check_num("datbus.stb count", o.n_dat, mem ? 1 : 0);
	if (mem && o.n_dat == 1)
	begin
		check_bit("datbus.write", o.dat_write, w.r.cls == T_STORE);
		check_be("datbus.byteenable", o.be, lane_mask(w.r.op, align));
	end
	check_num("ctl.reg_write count", o.n_wr, writes ? 1 : 0);
	if (writes && o.n_wr == 1)
	begin
		check_num("ctl.reg_write", o.wr_code, REG_WRITE_DW);
		check_reg_in("ctl.regsel", o.regsel,
			(w.r.cls == T_LDI && !w.r.size) ? REG_UVAL : REG_MDR);
		check_num("ctl.reg_write_addr", o.waddr, w.r.ra);
	end
	check_num("ctl.pcsel PC_REL count", o.n_rel,
		(!ill && w.r.cls == T_BRANCH && branch_taken(w.r.op, f)) ? 1 : 0);
	check_alu("ctl.alu_func", o.func, alu ? alufunc_t'(w.r.op[2:0]) : ALU_ADD);
	if (alu)
		check_num("ctl.alu2sel ALU_SVAL count", o.n_sval, w.r.op[3]);
endtask

// ==== tb/tb_control_unit.sv ====
`timescale 1ns/1ps

module tb_control_unit;
	import control_pkg::*;

	localparam int NUM_INSN     = 300;
	localparam int WINDOW_LIMIT = 80;
	localparam int HALT_WATCH   = 16;

	logic          clk_i;
	logic          rst_i;
	insn_u         ir;
	ccr_flags_t    ccr;
	logic          datbus_ack;
	logic [1:0]    datbus_align;
	logic          insbus_ack;
	datapath_ctl_t ctl;
	dat_bus_t      datbus;
	ins_bus_t      insbus;
	logic          halt;

	integer seed;
	int     value_errors;
	int     other_errors;
	int     insn_count;
	bit     stop_run;

	`include "control_checks.svh"

	obs_t obs;

	control_unit dut (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.ir           (ir),
		.ccr          (ccr),
		.datbus_ack   (datbus_ack),
		.datbus_align (datbus_align),
		.insbus_ack   (insbus_ack),
		.ctl          (ctl),
		.datbus       (datbus),
		.insbus       (insbus),
		.halt         (halt)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	function automatic int rand_below(input int n);
		return {$random(seed)} % n;
	endfunction

	function automatic insn_u make_word();
		insn_u w;
		int    pick;
		int    k;
		w    = $random(seed);
		pick = rand_below(100);
		if (pick < 2)
		begin
			k       = rand_below(10); // one of the unused class codes
			w.r.cls = 4'((k < 5) ? k + 1 : (k == 5) ? 7 : k + 6);
		end
		else if (pick < 4)
		begin
			w.r.cls  = rand_below(2) ? T_ALU : T_BRANCH;
			w.r.size = 1'b1;
		end
		else if (pick < 5)
		begin
			k       = rand_below(14) + 1; // any op but nop and halt
			w.r.cls = T_INH;
			w.r.op  = 4'((k < 4) ? k : k + 1);
		end
		else
		begin
			case (rand_below(6))
				0:       w.r.cls = T_INH;
				1:       w.r.cls = T_ALU;
				2:       w.r.cls = T_LDI;
				3:       w.r.cls = T_LOAD;
				4:       w.r.cls = T_STORE;
				default: w.r.cls = T_BRANCH;
			endcase
			if (w.r.cls == T_INH)
				w.r.op = (rand_below(4) == 0) ? INH_HALT : INH_NOP;
			if (w.r.cls == T_ALU || w.r.cls == T_BRANCH)
				w.r.size = 1'b0;
		end
		return w;
	endfunction

	task automatic apply_reset();
		@(posedge clk_i);
		#2;
		rst_i      = 1'b1;
		insbus_ack = 1'b0;
		datbus_ack = 1'b0;
		repeat (5)
			@(negedge clk_i);
		check_bit("insbus.cyc", insbus.cyc, 1'b0);
		check_bit("insbus.stb", insbus.stb, 1'b0);
		check_bit("datbus.cyc", datbus.cyc, 1'b0);
		check_bit("datbus.stb", datbus.stb, 1'b0);
		check_bit("datbus.write", datbus.write, 1'b0);
		check_bit("halt", halt, 1'b0);
		check_be("datbus.byteenable", datbus.byteenable, BE_WORD);
		@(posedge clk_i);
		#2;
		rst_i = 1'b0;
	endtask

	task automatic wait_fetch();
		int i;
		for (i = 0; i < WINDOW_LIMIT; i++)
		begin
			@(negedge clk_i);
			if (insbus.stb)
				return;
		end
		other_errors++;
		$display("Timeout: no instruction fetch started after reset");
		stop_run = 1'b1;
	endtask

	// one instruction from its fetch strobe to the next fetch strobe or halt
	task automatic run_window();
		insn_u      word;
		logic [1:0] align;
		ccr_flags_t flags;
		int         ins_wait;
		int         dat_wait;
		bit         fetching;
		bit         dat_busy;
		bit         dat_closing;
		int         i;
		int         j;
		word        = make_word();
		align       = 2'(rand_below(4));
		flags       = 3'(rand_below(8));
		obs         = '0;
		ins_wait    = rand_below(4);
		dat_wait    = -1;
		fetching    = 1'b1;
		dat_busy    = 1'b0;
		dat_closing = 1'b0;
		for (i = 0; i < WINDOW_LIMIT; i++)
		begin
			@(posedge clk_i);
			#2;
			insbus_ack = (ins_wait == 0);
			datbus_ack = (dat_wait == 0);
			if (ins_wait == 0 && fetching)
			begin
				ir           = word; // next instruction comes with the ack
				ccr          = flags;
				datbus_align = align;
				fetching     = 1'b0;
			end
			if (ins_wait >= 0)
				ins_wait--;
			if (dat_wait >= 0)
				dat_wait--;
			@(negedge clk_i);
			if (insbus_ack)
			begin
				check_bit("insbus.cyc", insbus.cyc, 1'b1);
				check_pc("ctl.pcsel", ctl.pcsel, PC_NEXT);
			end
			if (dat_closing)
				check_bit("datbus.cyc", datbus.cyc, 1'b0);
			dat_closing = 1'b0;
			if (dat_busy)
				check_bit("datbus.cyc", datbus.cyc, 1'b1); // held under back-pressure
			if (datbus_ack)
			begin
				dat_busy    = 1'b0;
				dat_closing = 1'b1;
			end
			if (insbus.stb && ctl.ir_write)
			begin
				expect_window(word, align, flags, obs);
				return;
			end
			if (insbus.stb)
			begin
				obs.n_arg = obs.n_arg + 1;
				ins_wait  = rand_below(4);
			end
			if (datbus.stb)
			begin
				obs.n_dat     = obs.n_dat + 1;
				obs.dat_write = datbus.write;
				obs.be        = datbus.byteenable;
				dat_wait      = rand_below(4);
				dat_busy      = 1'b1;
			end
			if (ctl.reg_write != REG_WRITE_NONE)
			begin
				obs.n_wr    = obs.n_wr + 1;
				obs.wr_code = ctl.reg_write;
				obs.regsel  = ctl.regsel;
				obs.waddr   = ctl.reg_write_addr;
			end
			if (ctl.pcsel == PC_REL)
				obs.n_rel = obs.n_rel + 1;
			if (ctl.alu_func != ALU_ADD)
				obs.func = ctl.alu_func;
			if (ctl.alu2sel == ALU_SVAL)
				obs.n_sval = obs.n_sval + 1;
			if (halt)
			begin
				obs.halted = 1'b1;
				for (j = 0; j < HALT_WATCH; j++)
				begin
					@(negedge clk_i);
					check_bit("halt", halt, 1'b1);
					check_bit("insbus.stb", insbus.stb, 1'b0);
				end
				expect_window(word, align, flags, obs);
				return;
			end
		end
		other_errors++;
		$display("Timeout: instruction %0d never reached the next fetch or halt", insn_count);
		stop_run = 1'b1;
	endtask

	initial
	begin
		seed         = 32'hab088cd0;
		rst_i        = 1'b1;
		ir           = '0;
		ccr          = '0;
		datbus_ack   = 1'b0;
		datbus_align = 2'd0;
		insbus_ack   = 1'b0;
		value_errors = 0;
		other_errors = 0;
		insn_count   = 0;
		stop_run     = 1'b0;
		apply_reset();
		wait_fetch();
		while (!stop_run && insn_count < NUM_INSN)
		begin
			run_window();
			insn_count++;
			if (!stop_run && obs.halted)
			begin
				apply_reset(); // restart after each halt
				wait_fetch();
			end
		end
		$display("%0d instructions, %0d value errors, %0d timeout errors",
			insn_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+tb
verilog/control_pkg.sv
verilog/insn_decoder.sv
verilog/branch_resolver.sv
verilog/bus_sequencer.sv
verilog/control_fsm.sv
verilog/control_unit.sv
tb/tb_control_unit.sv
